// File: game_gfx.f
+incdir+logic
logic/gfx_pkg.sv
logic/game_pkg.sv
logic/pixel_if.sv
logic/marker_painter.sv
logic/block_placer.sv
logic/pixel_arbiter.sv
logic/game_gfx.sv
verification/game_gfx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module game_gfx_tb -f game_gfx.f \
	--Mdir obj_dir -o sim_game_gfx > build.log 2>&1 \
	&& ./obj_dir/sim_game_gfx > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
grep -q "^SIMULATION PASSED$" sim.log && echo "run ok" || { cat sim.log; exit 1; }

// File: verification/game_gfx_tb.sv
/* directed testbench for the drawing side
   expected beats follow the drawing rules and are compared with every transferred beat */
`timescale 1ns/1ns
`include "game_gfx_config.svh"

module game_gfx_tb;

	typedef struct packed {
		gfx_pkg::xcoord_t x;
		gfx_pkg::ycoord_t y;
		gfx_pkg::colour_t colour;
	} beat_t;

	localparam int max_cycles = 4000;

	logic                  clk;
	logic                  reset_n;
	game_pkg::game_state_t game_state;
	game_pkg::key_code_t   key_code;
	logic                  key_pressed;
	logic                  tall_block;
	logic                  plot_ready;
	logic                  stall_en;     // random back-pressure on plot_ready
	gfx_pkg::xcoord_t      x;
	gfx_pkg::ycoord_t      y;
	gfx_pkg::colour_t      colour;
	logic                  plot;
	game_pkg::block_word_t block_word;
	logic                  block_placed;
	beat_t                 got_q[$];
	beat_t                 exp_q[$];
	int                    errors;
	int                    cycles;
	int unsigned           seed;

	game_gfx u_dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.game_state   (game_state),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.tall_block   (tall_block),
		.plot_ready   (plot_ready),
		.x            (x),
		.y            (y),
		.colour       (colour),
		.plot         (plot),
		.block_word   (block_word),
		.block_placed (block_placed)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// frame-buffer ready drops about one cycle in 4 while stalling
	initial begin
		seed = $urandom(90365);
		plot_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1 plot_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
		end
	end

	// every beat accepted by the frame-buffer writer
	always @(posedge clk) begin
		if (reset_n && plot && plot_ready)
			got_q.push_back({x, y, colour});
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic set_state(input game_pkg::game_state_t s);
		next_cycle();
		game_state = s;
	endtask

	task automatic press_key(input game_pkg::key_code_t k);
		next_cycle();
		key_code = k;
		key_pressed = 1'b1;
		next_cycle();
		key_pressed = 1'b0;
	endtask

	task automatic check_pixel(input int idx, input gfx_pkg::xcoord_t exp_x,
		input gfx_pkg::ycoord_t exp_y, input gfx_pkg::colour_t exp_c,
		input gfx_pkg::xcoord_t act_x, input gfx_pkg::ycoord_t act_y,
		input gfx_pkg::colour_t act_c);
		if (act_x !== exp_x) begin
			errors++;
			$display("Error: x at beat %0d expected %h got %h", idx, exp_x, act_x);
		end
		if (act_y !== exp_y) begin
			errors++;
			$display("Error: y at beat %0d expected %h got %h", idx, exp_y, act_y);
		end
		if (act_c !== exp_c) begin
			errors++;
			$display("Error: colour at beat %0d expected %h got %h", idx, exp_c, act_c);
		end
	endtask

	task automatic check_block(input game_pkg::block_word_t exp_w, input logic exp_placed);
		if (block_word !== exp_w) begin
			errors++;
			$display("Error: block_word expected %h got %h", exp_w, block_word);
		end
		if (block_placed !== exp_placed) begin
			errors++;
			$display("Error: block_placed expected %h got %h", exp_placed, block_placed);
		end
	endtask

	// row-major 4x4 square at the marker column
	task automatic add_marker(input gfx_pkg::ycoord_t row, input gfx_pkg::colour_t c);
		int dx;
		int dy;
		for (dy = 0; dy < `GFX_MARKER_SIZE; dy++)
			for (dx = 0; dx < `GFX_MARKER_SIZE; dx++)
				exp_q.push_back({gfx_pkg::xcoord_t'(`GFX_MARKER_X + dx),
					gfx_pkg::ycoord_t'(int'(row) + dy), c});
	endtask

	// row-major walk over the 32x2 wide or 2x32 tall footprint
	task automatic add_block(input game_pkg::block_word_t pos, input gfx_pkg::colour_t c);
		int w;
		int h;
		int dx;
		int dy;
		w = pos.tall ? `GFX_BLOCK_SHORT : `GFX_BLOCK_LONG;
		h = pos.tall ? `GFX_BLOCK_LONG : `GFX_BLOCK_SHORT;
		for (dy = 0; dy < h; dy++)
			for (dx = 0; dx < w; dx++)
				exp_q.push_back({gfx_pkg::xcoord_t'(int'(pos.col) + dx),
					gfx_pkg::ycoord_t'(int'(pos.row) + dy), c});
	endtask

	task automatic compare_beats();
		int i;
		while (got_q.size() < exp_q.size())
			next_cycle();
		repeat (8) next_cycle();  // room for stray beats
		if (got_q.size() != exp_q.size()) begin
			errors++;
			$display("beat count mismatch, expected %0d beats but %0d transferred",
				exp_q.size(), got_q.size());
		end
		for (i = 0; i < exp_q.size() && i < got_q.size(); i++)
			check_pixel(i, exp_q[i].x, exp_q[i].y, exp_q[i].colour,
				got_q[i].x, got_q[i].y, got_q[i].colour);
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic show_marker(input game_pkg::game_state_t s, input int row,
		input gfx_pkg::colour_t c);
		add_marker(gfx_pkg::ycoord_t'(row), c);
		set_state(s);
		compare_beats();
	endtask

	function automatic game_pkg::block_word_t start_word(input logic tall);
		return '{row: 7'(`GFX_INIT_ROW), col: 8'(`GFX_INIT_COL), tall: tall};
	endfunction

	// load_block marker and then the first red footprint
	task automatic enter_draw(input logic tall);
		show_marker(game_pkg::gs_load_block, `GFX_ROW_LOAD_BLOCK, `GFX_RED);
		tall_block = tall;
		add_block(start_word(tall), `GFX_RED);
		set_state(game_pkg::gs_draw_block);
		compare_beats();
	endtask

	task automatic move_block(input game_pkg::key_code_t k,
		input game_pkg::block_word_t from, input game_pkg::block_word_t to);
		add_block(from, `GFX_BLACK);
		add_block(to, `GFX_RED);
		press_key(k);
		compare_beats();
		check_block(to, 1'b0);
	endtask

	task automatic test_reset();
		if (plot !== 1'b0) begin
			errors++;
			$display("Error: plot expected %h got %h", 1'b0, plot);
		end
		check_block(start_word(1'b0), 1'b0);
		compare_beats();
	endtask

	task automatic test_markers();
		show_marker(game_pkg::gs_begin, `GFX_ROW_BEGIN, `GFX_RED);
		show_marker(game_pkg::gs_begin_wait, `GFX_ROW_BEGIN, `GFX_BLACK);
		show_marker(game_pkg::gs_load_block, `GFX_ROW_LOAD_BLOCK, `GFX_RED);
		show_marker(game_pkg::gs_end_game, `GFX_ROW_END, `GFX_RED);
		set_state(game_pkg::gs_start_game);  // no marker for this one
		compare_beats();
	endtask

	task automatic test_moves(input logic tall);
		game_pkg::block_word_t start;
		game_pkg::block_word_t right;
		game_pkg::block_word_t down;
		start = start_word(tall);
		right = start;
		right.col = start.col + 8'(`GFX_STEP);
		down = right;
		down.row = right.row + 7'(`GFX_STEP);
		enter_draw(tall);
		move_block(game_pkg::key_right, start, right);
		move_block(game_pkg::key_down, right, down);
	endtask

	task automatic test_bounds();
		enter_draw(1'b0);
		press_key(game_pkg::key_left);  // col 8 would wrap below the left bound
		compare_beats();
		press_key(game_pkg::key_up);
		compare_beats();
		check_block(start_word(1'b0), 1'b0);
	endtask

	task automatic test_placing();
		add_block(start_word(1'b0), `GFX_MAGENTA);
		press_key(game_pkg::key_space);
		compare_beats();
		check_block(start_word(1'b0), 1'b1);
		press_key(game_pkg::key_right);  // block is fixed now
		compare_beats();
		check_block(start_word(1'b0), 1'b1);
	endtask

	// marker request lands in the middle of the erase burst
	task automatic test_merge();
		game_pkg::block_word_t right;
		right = start_word(1'b0);
		right.col = right.col + 8'(`GFX_STEP);
		enter_draw(1'b0);
		add_block(start_word(1'b0), `GFX_BLACK);
		add_marker(gfx_pkg::ycoord_t'(`GFX_ROW_END), `GFX_RED);
		add_block(right, `GFX_RED);
		press_key(game_pkg::key_right);
		repeat (4) next_cycle();
		game_state = game_pkg::gs_end_game;
		compare_beats();
		check_block(right, 1'b0);
	endtask

	initial begin
		errors = 0;
		cycles = 0;
		reset_n = 1'b0;
		game_state = game_pkg::gs_start_game;
		key_code = game_pkg::key_space;
		key_pressed = 1'b0;
		tall_block = 1'b0;
		stall_en = 1'b0;
		repeat (5) @(posedge clk);
		#1 reset_n = 1'b1;
		test_reset();
		test_markers();
		test_moves(1'b0);
		test_moves(1'b1);
		test_bounds();
		test_placing();
		stall_en = 1'b1;
		test_markers();
		test_moves(1'b0);
		test_merge();
		$display("%0d errors", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: logic/game_gfx.sv
/* top level of the drawing side, marker painter and block placer
   feed the arbiter, which drives the vga frame-buffer writer */
`timescale 1ns/1ns

module game_gfx (
	input  logic                  clk,
	input  logic                  reset_n,
	input  game_pkg::game_state_t game_state,
	input  game_pkg::key_code_t   key_code,
	input  logic                  key_pressed,   // one-cycle pulse per make code
	input  logic                  tall_block,
	input  logic                  plot_ready,
	output gfx_pkg::xcoord_t      x,
	output gfx_pkg::ycoord_t      y,
	output gfx_pkg::colour_t      colour,
	output logic                  plot,
	output game_pkg::block_word_t block_word,
	output logic                  block_placed
);

	pixel_if u_marker_px ();
	pixel_if u_block_px ();

	marker_painter u_marker (
		.clk        (clk),
		.reset_n    (reset_n),
		.game_state (game_state),
		.px         (u_marker_px.source)
	);

	block_placer u_block (
		.clk          (clk),
		.reset_n      (reset_n),
		.game_state   (game_state),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.tall_block   (tall_block),
		.px           (u_block_px.source),
		.block_word   (block_word),
		.block_placed (block_placed)
	);

	pixel_arbiter u_arb (
		.clk        (clk),
		.reset_n    (reset_n),
		.marker_px  (u_marker_px.sink),
		.block_px   (u_block_px.sink),
		.x          (x),
		.y          (y),
		.colour     (colour),
		.plot       (plot),
		.plot_ready (plot_ready)
	);

endmodule

// File: logic/pixel_arbiter.sv
/* merges the marker and block pixel streams onto the frame-buffer port
   a granted burst runs to its last beat before the other source gets in */
`timescale 1ns/1ns

module pixel_arbiter (
	input  logic             clk,
	input  logic             reset_n,
	pixel_if.sink            marker_px,
	pixel_if.sink            block_px,
	output gfx_pkg::xcoord_t x,
	output gfx_pkg::ycoord_t y,
	output gfx_pkg::colour_t colour,
	output logic             plot,
	input  logic             plot_ready
);

	logic grant;      // 0 marker, 1 block
	logic locked;     // inside a burst
	logic next_grant;
	logic sel_valid;
	logic sel_last;
	logic beat;
	logic burst_end;

	assign sel_valid = grant ? block_px.valid : marker_px.valid;
	assign sel_last = grant ? block_px.last : marker_px.last;
	assign beat = sel_valid && plot_ready;
	assign burst_end = beat && sel_last;

	// marker first when both wait
	assign next_grant = marker_px.valid ? 1'b0 : (block_px.valid ? 1'b1 : grant);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			grant <= 1'b0;
			locked <= 1'b0;
		end else begin
			if (beat)
				locked <= !sel_last;
			if (burst_end || (!locked && !sel_valid))
				grant <= next_grant;
		end
	end

	// zero-latency forward of the granted stream
	assign plot = sel_valid;
	assign x = grant ? block_px.x : marker_px.x;
	assign y = grant ? block_px.y : marker_px.y;
	assign colour = grant ? block_px.colour : marker_px.colour;

	assign marker_px.ready = !grant && plot_ready;
	assign block_px.ready = grant && plot_ready;

	// granted source stays valid and keeps the grant mid-burst
	a_grant_locked: assert property (@(posedge clk) disable iff (!reset_n)
		beat && !sel_last |=> sel_valid && $stable(grant));

endmodule

// File: logic/block_placer.sv
/* keyboard-driven block placement during the draw-block state
   erases the old footprint, draws the new one and paints it magenta on space */
`timescale 1ns/1ns
`include "game_gfx_config.svh"

module block_placer (
	input  logic                  clk,
	input  logic                  reset_n,
	input  game_pkg::game_state_t game_state,
	input  game_pkg::key_code_t   key_code,
	input  logic                  key_pressed,
	input  logic                  tall_block,
	pixel_if.source               px,
	output game_pkg::block_word_t block_word,
	output logic                  block_placed
);

	typedef enum logic [1:0] {
		ph_idle,
		ph_erase,   // black at the old position
		ph_draw,    // red at the current position
		ph_placed   // magenta, block fixed afterwards
	} phase_t;

	phase_t                phase;
	logic [5:0]            cnt;
	game_pkg::block_word_t pos;
	game_pkg::block_word_t new_pos;   // target of an accepted move
	game_pkg::block_word_t move_pos;
	game_pkg::game_state_t prev_state;
	logic                  is_arrow;
	logic                  move_ok;
	logic                  enter_draw;
	logic                  key_take;
	logic                  beat_done;
	logic                  burst_end;
	logic [5:0]            dx;
	logic [5:0]            dy;
	gfx_pkg::colour_t      colour;

	assign enter_draw = (game_state == game_pkg::gs_draw_block)
		&& (prev_state != game_pkg::gs_draw_block);
	assign key_take = (game_state == game_pkg::gs_draw_block) && key_pressed && !block_placed;
	assign beat_done = px.valid && px.ready;
	assign burst_end = beat_done && px.last;

	// candidate position for an arrow key
	always_comb begin
		move_pos = pos;
		is_arrow = 1'b1;
		case (key_code)
			game_pkg::key_left:  move_pos.col = pos.col - 8'(`GFX_STEP);
			game_pkg::key_right: move_pos.col = pos.col + 8'(`GFX_STEP);
			game_pkg::key_up:    move_pos.row = pos.row - 7'(`GFX_STEP);
			game_pkg::key_down:  move_pos.row = pos.row + 7'(`GFX_STEP);
			default:             is_arrow = 1'b0;
		endcase
	end

	// wrap-around lands outside the range as well
	assign move_ok = is_arrow
		&& (move_pos.col > 8'(`GFX_COL_MIN)) && (move_pos.col < 8'(`GFX_COL_MAX))
		&& (move_pos.row > 7'(`GFX_ROW_MIN)) && (move_pos.row < 7'(`GFX_ROW_MAX));

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			phase <= ph_idle;
			cnt <= 6'd0;
			pos <= '{row: 7'(`GFX_INIT_ROW), col: 8'(`GFX_INIT_COL), tall: 1'b0};
			block_placed <= 1'b0;
			prev_state <= game_state;
		end else begin
			prev_state <= game_state;
			if (beat_done)
				cnt <= cnt + 6'd1;  // 64 beats per burst, back at 0 after each
			case (phase)
				ph_idle: begin
					if (game_state == game_pkg::gs_load_block) begin
						pos <= '{row: 7'(`GFX_INIT_ROW), col: 8'(`GFX_INIT_COL), tall: 1'b0};
						block_placed <= 1'b0;
					end else if (enter_draw) begin
						pos.tall <= tall_block;  // footprint fixed for this round
						phase <= ph_draw;
					end else if (key_take) begin
						if (key_code == game_pkg::key_space) begin
							phase <= ph_placed;
						end else if (move_ok) begin
							new_pos <= move_pos;
							phase <= ph_erase;
						end
					end
				end
				ph_erase: begin
					if (burst_end) begin
						pos <= new_pos;
						phase <= ph_draw;
					end
				end
				ph_draw: begin
					if (burst_end)
						phase <= ph_idle;
				end
				ph_placed: begin
					if (burst_end) begin
						block_placed <= 1'b1;
						phase <= ph_idle;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	always_comb begin
		case (phase)
			ph_erase:  colour = `GFX_BLACK;
			ph_placed: colour = `GFX_MAGENTA;
			default:   colour = `GFX_RED;
		endcase
	end

	// row-major over 32x2 or 2x32
	assign dx = pos.tall ? cnt % 6'(`GFX_BLOCK_SHORT) : cnt % 6'(`GFX_BLOCK_LONG);
	assign dy = pos.tall ? cnt / 6'(`GFX_BLOCK_SHORT) : cnt / 6'(`GFX_BLOCK_LONG);

	assign px.valid = (phase != ph_idle);
	assign px.x = gfx_pkg::xcoord_t'(pos.col) + gfx_pkg::xcoord_t'(dx);
	assign px.y = gfx_pkg::ycoord_t'(pos.row) + gfx_pkg::ycoord_t'(dy);
	assign px.colour = colour;
	assign px.last = (cnt == 6'(`GFX_BLOCK_LONG * `GFX_BLOCK_SHORT - 1));

	assign block_word = pos;

	// the reported block never leaves the playing field
	a_block_in_bounds: assert property (@(posedge clk) disable iff (!reset_n)
		(block_word.col > 8'(`GFX_COL_MIN)) && (block_word.col < 8'(`GFX_COL_MAX))
		&& (block_word.row > 7'(`GFX_ROW_MIN)) && (block_word.row < 7'(`GFX_ROW_MAX)));

endmodule

// File: logic/marker_painter.sv
/* paints the 4x4 status marker each time the game moves to a new state
   red for draw states, black for wait states, one row per state pair */
`timescale 1ns/1ns
`include "game_gfx_config.svh"

module marker_painter (
	input  logic                  clk,
	input  logic                  reset_n,
	input  game_pkg::game_state_t game_state,
	pixel_if.source               px
);

	logic                  busy;
	logic [3:0]            cnt;         // beat within the marker
	game_pkg::game_state_t prev_state;
	game_pkg::game_state_t cur_state;   // state being painted
	game_pkg::game_state_t pend_state;
	logic                  pend_valid;
	logic                  state_chg;
	logic                  beat_done;
	logic                  burst_end;
	logic [3:0]            dx;
	logic [3:0]            dy;
	gfx_pkg::ycoord_t      row;
	gfx_pkg::colour_t      colour;

	// draw_block and start_game have no marker
	function automatic logic is_marker(input game_pkg::game_state_t s);
		case (s)
			game_pkg::gs_begin, game_pkg::gs_begin_wait,
			game_pkg::gs_load_block, game_pkg::gs_load_block_wait,
			game_pkg::gs_load_set, game_pkg::gs_load_set_wait,
			game_pkg::gs_start_load, game_pkg::gs_start_wait,
			game_pkg::gs_end_game, game_pkg::gs_end_wait: is_marker = 1'b1;
			default:                                      is_marker = 1'b0;
		endcase
	endfunction

	assign state_chg = (game_state != prev_state) && is_marker(game_state);
	assign beat_done = busy && px.ready;
	assign burst_end = beat_done && px.last;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			prev_state <= game_state;  // no marker for the state held in reset
			busy <= 1'b0;
			cnt <= 4'd0;
			pend_valid <= 1'b0;
		end else begin
			prev_state <= game_state;
			if (beat_done)
				cnt <= cnt + 4'd1;  // wraps to 0 on the last beat
			if (!busy || burst_end) begin
				if (state_chg) begin
					busy <= 1'b1;
					cur_state <= game_state;  // newest change beats the pending one
				end else if (pend_valid) begin
					busy <= 1'b1;
					cur_state <= pend_state;
				end else begin
					busy <= 1'b0;
				end
				pend_valid <= 1'b0;
			end else if (state_chg) begin
				pend_valid <= 1'b1;
				pend_state <= game_state;
			end
		end
	end

	// row and colour for the state being painted
	always_comb begin
		row = gfx_pkg::ycoord_t'(`GFX_ROW_BEGIN);
		colour = `GFX_BLACK;
		case (cur_state)
			game_pkg::gs_begin: colour = `GFX_RED;
			game_pkg::gs_load_block: begin
				row = gfx_pkg::ycoord_t'(`GFX_ROW_LOAD_BLOCK);
				colour = `GFX_RED;
			end
			game_pkg::gs_load_block_wait: row = gfx_pkg::ycoord_t'(`GFX_ROW_LOAD_BLOCK);
			game_pkg::gs_load_set: begin
				row = gfx_pkg::ycoord_t'(`GFX_ROW_LOAD_SET);
				colour = `GFX_RED;
			end
			game_pkg::gs_load_set_wait: row = gfx_pkg::ycoord_t'(`GFX_ROW_LOAD_SET);
			game_pkg::gs_start_load: begin
				row = gfx_pkg::ycoord_t'(`GFX_ROW_START);
				colour = `GFX_RED;
			end
			game_pkg::gs_start_wait: row = gfx_pkg::ycoord_t'(`GFX_ROW_START);
			game_pkg::gs_end_game: begin
				row = gfx_pkg::ycoord_t'(`GFX_ROW_END);
				colour = `GFX_RED;
			end
			game_pkg::gs_end_wait: row = gfx_pkg::ycoord_t'(`GFX_ROW_END);
			default: ;  // begin_wait keeps the defaults
		endcase
	end

	// row-major walk over the square
	assign dx = cnt % 4'(`GFX_MARKER_SIZE);
	assign dy = cnt / 4'(`GFX_MARKER_SIZE);

	assign px.valid = busy;
	assign px.x = gfx_pkg::xcoord_t'(`GFX_MARKER_X) + gfx_pkg::xcoord_t'(dx);
	assign px.y = row + gfx_pkg::ycoord_t'(dy);
	assign px.colour = colour;
	assign px.last = (cnt == 4'(`GFX_MARKER_SIZE * `GFX_MARKER_SIZE - 1));

	// a stalled beat must not change under the arbiter
	a_hold_stalled_beat: assert property (@(posedge clk) disable iff (!reset_n)
		px.valid && !px.ready |=> px.valid && $stable(px.x) && $stable(px.y)
			&& $stable(px.colour));

endmodule

// File: logic/pixel_if.sv
/* valid/ready pixel stream from one drawing source to the arbiter
   a beat moves when valid and ready are both high, last marks the burst end */
`timescale 1ns/1ns

interface pixel_if;

	logic              valid;
	logic              ready;
	gfx_pkg::xcoord_t  x;
	gfx_pkg::ycoord_t  y;
	gfx_pkg::colour_t  colour;
	logic              last;

	modport source (output valid, x, y, colour, last, input ready);
	modport sink (input valid, x, y, colour, last, output ready);

endinterface

// File: logic/game_pkg.sv
/* game phase, keyboard make codes and the placed-block word
   shared by the painters, the top level and the testbench */
package game_pkg;

	// phase of the game, one marker row per draw/wait pair
	typedef enum logic [3:0] {
		gs_begin           = 4'd0,
		gs_begin_wait      = 4'd1,
		gs_load_block      = 4'd2,
		gs_load_block_wait = 4'd3,
		gs_load_set        = 4'd4,
		gs_draw_block      = 4'd5,
		gs_load_set_wait   = 4'd6,
		gs_start_load      = 4'd7,
		gs_start_game      = 4'd8,
		gs_start_wait      = 4'd9,
		gs_end_game        = 4'd10,
		gs_end_wait        = 4'd12
	} game_state_t;

	// ps/2 make codes the block placer reacts to
	typedef enum logic [7:0] {
		key_left  = 8'h6B,
		key_right = 8'h74,
		key_up    = 8'h75,
		key_down  = 8'h72,
		key_space = 8'h29
	} key_code_t;

	// block position and orientation as handed to the game logic
	typedef struct packed {
		logic [6:0] row;   // top edge
		logic [7:0] col;   // left edge
		logic       tall;  // 2x32 when set, 32x2 otherwise
	} block_word_t;

endpackage

// File: logic/gfx_pkg.sv
/* pixel coordinate and colour types for every module on the pixel stream */
package gfx_pkg;

`include "game_gfx_config.svh"

	// horizontal position on the frame buffer
	typedef logic [`GFX_X_BITS-1:0] xcoord_t;

	// vertical position on the frame buffer
	typedef logic [`GFX_Y_BITS-1:0] ycoord_t;

	// rgb, one bit per channel
	typedef logic [`GFX_COLOUR_BITS-1:0] colour_t;

endpackage

// File: logic/game_gfx_config.svh
/* screen geometry, marker rows, colours and block limits for the drawing side
   include wherever the drawing modules need a constant */
`ifndef GAME_GFX_CONFIG_SVH
`define GAME_GFX_CONFIG_SVH

// frame-buffer coordinate and colour widths
`define GFX_X_BITS       12
`define GFX_Y_BITS       11
`define GFX_COLOUR_BITS  3

// status marker column and one row per state pair
`define GFX_MARKER_X        122
`define GFX_ROW_BEGIN       18
`define GFX_ROW_LOAD_BLOCK  39
`define GFX_ROW_LOAD_SET    58
`define GFX_ROW_START       76
`define GFX_ROW_END         94

// block movement, a move must land strictly inside min..max
`define GFX_STEP     15
`define GFX_COL_MIN  7
`define GFX_COL_MAX  116
`define GFX_ROW_MIN  3
`define GFX_ROW_MAX  116
`define GFX_INIT_ROW 7
`define GFX_INIT_COL 8

// footprint sizes in pixels
`define GFX_BLOCK_LONG   32
`define GFX_BLOCK_SHORT  2
`define GFX_MARKER_SIZE  4

// 3-bit rgb
`define GFX_BLACK    3'd0
`define GFX_RED      3'd4
`define GFX_MAGENTA  3'd5

`endif
